// File: bench/scurveBench.sv
module scurveBench;
  timeunit 1ns;
  timeprecision 100ps;
  import asicPkg::*;
  import daqPkg::*;

  localparam int DacLast     = 3;
  localparam int NumTests    = 5;
  localparam int DoneTimeout = 200000;  // Cycles, covers a full 64-channel sweep

  typedef struct packed {
    logic    single;
    chanIdxT chan;
    logic    inject;
    logic    toggleFull;  // Random usbFull during count words
  } testRowT;

  testRowT           testTable [NumTests];
  logic              Clk = 1'b0;
  logic              reset_n;
  logic              testStart;
  logic              singleChan;
  chanIdxT           singleChanIdx;
  logic              ctestInject;
  logic [63:0]       asicTrigger = '0;
  logic              usbFull = 1'b0;
  logic              transmitDone;
  dataWordT          usbData;
  logic              usbWrite;
  logic              testDone;
  logic              scSerial;
  logic              scShift;
  logic              scLatch;
  logic              testBegin;
  logic              testEnd;
  logic              toggleFull = 1'b0;
  logic              countPhase = 1'b0;
  logic              timedOut;
  logic [ScBits-1:0] chipWord = '0;
  scParamT           latched;
  chanIdxT           pulseChan;
  int                pulses;
  int                errCount;
  int                testsRun;
  int unsigned       seedDummy;

  always #20 Clk = ~Clk;

  scurveTop #(.DacLast(DacLast), .SettleCycles(4), .WindowCycles(40), .FifoDepth(4)) dut0 (
    .Clk, .reset_n, .testStart, .singleChan, .singleChanIdx, .ctestInject, .asicTrigger,
    .usbFull, .transmitDone, .usbData, .usbWrite, .testDone, .scSerial, .scShift, .scLatch
  );

  scurveChecker #(.DacLast(DacLast)) checker0 (
    .Clk, .testBegin, .testEnd, .expSingle(singleChan), .expChan(singleChanIdx),
    .expInject(ctestInject), .usbWrite, .usbData, .usbFull, .scShift, .scSerial, .scLatch,
    .testDone, .transmitDone, .errCount
  );

  ////////////////////
  // Chip model
  function automatic chanIdxT pulseChannel(scParamT w, logic inject);
    chanIdxT ch;
    ch = '0;
    for (int c = 63; c >= 0; c--) begin
      if (inject ? w.ctestMask[c] : w.discriMask[$bits(discriMaskT) - 1 - 3 * c]) begin
        ch = chanIdxT'(c);
      end
    end
    return ch;
  endfunction

  function automatic int pulseCount(dacCodeT bits);
    dacCodeT code;
    code = {<<{bits}};
    return 3 * (DacLast - int'(code)) + 1;
  endfunction

  always @(posedge Clk) begin
    if (scShift) begin
      chipWord <= {chipWord[ScBits-2:0], scSerial};
    end
  end

  // Trigger pulses start once the settle time has passed
  always begin
    @(posedge Clk);
    if (scLatch) begin
      latched   = chipWord;
      pulseChan = pulseChannel(latched, ctestInject);
      pulses    = pulseCount(latched.dacBits);
      repeat (6) @(posedge Clk);
      for (int k = 0; k < pulses; k++) begin
        #2 asicTrigger[pulseChan] = 1'b1;
        @(posedge Clk);
        #2 asicTrigger[pulseChan] = 1'b0;
        repeat (3) @(posedge Clk);
      end
    end
  end

  // Output FIFO fill, only ever high while a count word is pending
  always @(posedge Clk) begin
    if (scLatch) begin
      countPhase = 1'b1;
    end else if (usbWrite) begin
      countPhase = 1'b0;
    end
    #2 usbFull = countPhase && toggleFull && ($urandom_range(0, 1) == 1);
  end

  task automatic runTest(input int t);
    int waitCycles;
    @(posedge Clk);
    #2;
    singleChan    = testTable[t].single;
    singleChanIdx = testTable[t].chan;
    ctestInject   = testTable[t].inject;
    toggleFull    = testTable[t].toggleFull;
    testStart     = 1'b1;
    testBegin     = 1'b1;
    @(posedge Clk);
    #2;
    testStart  = 1'b0;
    testBegin  = 1'b0;
    waitCycles = 0;
    while (!testDone && waitCycles < DoneTimeout) begin
      @(posedge Clk);
      #2;
      waitCycles++;
    end
    if (!testDone) begin
      $display("Timeout in test %0d, testDone never rose", t);
      timedOut = 1'b1;
      return;
    end
    repeat ($urandom_range(1, 8)) @(posedge Clk);  // testDone must hold meanwhile
    #2 transmitDone = 1'b1;
    @(posedge Clk);
    #2 transmitDone = 1'b0;
    waitCycles = 0;
    while (testDone && waitCycles < 10) begin
      @(posedge Clk);
      #2;
      waitCycles++;
    end
    if (testDone) begin
      $display("Timeout in test %0d, testDone stayed high after transmitDone", t);
      timedOut = 1'b1;
      return;
    end
    testEnd = 1'b1;
    @(posedge Clk);
    #2 testEnd = 1'b0;
    testsRun++;
  endtask

  initial begin
    seedDummy     = $urandom(32'h5c98acf9);
    reset_n       = 1'b0;
    testStart     = 1'b0;
    singleChan    = 1'b0;
    singleChanIdx = '0;
    ctestInject   = 1'b0;
    transmitDone  = 1'b0;
    testBegin     = 1'b0;
    testEnd       = 1'b0;
    timedOut      = 1'b0;
    testsRun      = 0;
    // single, channel, inject, random usbFull
    testTable[0] = '{1'b1, 6'd5, 1'b1, 1'b0};
    testTable[1] = '{1'b1, 6'd5, 1'b1, 1'b1};   // Same stream under back-pressure
    testTable[2] = '{1'b1, 6'd42, 1'b0, 1'b1};
    testTable[3] = '{1'b0, 6'd0, 1'b1, 1'b0};
    testTable[4] = '{1'b0, 6'd0, 1'b0, 1'b1};
    repeat (5) @(posedge Clk);
    #2 reset_n = 1'b1;
    for (int t = 0; t < NumTests && !timedOut; t++) begin
      runTest(t);
    end
    repeat (2) @(posedge Clk);
    $display("Tests run: %0d of %0d, errors: %0d", testsRun, NumTests, errCount);
    if (timedOut || errCount != 0) begin
      $display("STATUS: FAIL");
    end else begin
      $display("STATUS: PASS");
    end
    $finish;
  end

endmodule

// File: bench/scurveChecker.sv
module scurveChecker #(
  parameter int DacLast = 3
) (
  input  logic             Clk,
  input  logic             testBegin,
  input  logic             testEnd,
  input  logic             expSingle,
  input  asicPkg::chanIdxT expChan,
  input  logic             expInject,
  input  logic             usbWrite,
  input  daqPkg::dataWordT usbData,
  input  logic             usbFull,
  input  logic             scShift,
  input  logic             scSerial,
  input  logic             scLatch,
  input  logic             testDone,
  input  logic             transmitDone,
  output int               errCount
);
  timeunit 1ns;
  timeprecision 100ps;
  import asicPkg::*;
  import daqPkg::*;

  dataWordT          expWords [$];   // Remaining words of the running test
  scParamT           expLoads [$];
  dataWordT          expWord;
  scParamT           expLoad;
  logic [ScBits-1:0] shiftWord = '0;
  logic              prevDone = 1'b0;
  logic              prevTransmit = 1'b0;
  int                testNum = 0;
  int                testErrors = 0;
  int                failures = 0;

  assign errCount = failures;

  task automatic noteFailure(string msg);
    $display("%s", msg);
    testErrors++;
    failures++;
  endtask

  task automatic compareValue(string name, logic [ScBits-1:0] got, logic [ScBits-1:0] exp);
    if (got !== exp) begin
      noteFailure($sformatf("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  ////////////////////
  // Expected stream and slow-control words of one test
  task automatic buildExpected();
    int      first;
    int      last;
    dacCodeT code;
    scParamT load;
    expWords.delete();
    expLoads.delete();
    first = expSingle ? int'(expChan) : 0;
    last  = expSingle ? int'(expChan) : 63;
    expWords.push_back(HeaderWord);
    for (int c = first; c <= last; c++) begin
      expWords.push_back({expSingle ? TagSingleChan : TagAllChan, 2'b00, chanIdxT'(c)});
      load.ctestMask = '0;
      if (expInject) begin
        load.ctestMask[c] = 1'b1;   // One-hot on the tested channel
      end
      load.discriMask = '0;
      load.discriMask[$bits(discriMaskT) - 1 - 3 * c -: 3] = 3'b111;
      for (int d = 0; d <= DacLast; d++) begin
        code         = dacCodeT'(d);
        load.dacBits = {<<{code}};  // LSB first on the chip side
        expWords.push_back({TagDac, 2'b00, code});
        expWords.push_back(dataWordT'(3 * (DacLast - d) + 1));
        expLoads.push_back(load);
      end
    end
    expWords.push_back(TrailerWord);
  endtask

  always @(posedge Clk) begin
    if (testBegin) begin
      buildExpected();
      testErrors = 0;
    end
    if (scShift) begin
      shiftWord = {shiftWord[ScBits-2:0], scSerial};
    end
    if (scLatch) begin
      if (expLoads.size() == 0) begin
        noteFailure("Slow-control word latched outside the expected sweep");
      end else begin
        expLoad = expLoads.pop_front();
        compareValue("scParam.ctestMask", ScBits'(shiftWord[ScBits-1 -: 64]),
                     ScBits'(expLoad.ctestMask));
        compareValue("scParam.dacBits", ScBits'(shiftWord[192 +: 10]), ScBits'(expLoad.dacBits));
        compareValue("scParam.discriMask", ScBits'(shiftWord[191:0]), ScBits'(expLoad.discriMask));
      end
    end
    ////////////////////
    // Output stream
    if (usbWrite) begin
      if (usbFull) begin
        noteFailure($sformatf("Word 0x%h written while usbFull was high", usbData));
      end
      if (expWords.size() == 0) begin
        noteFailure($sformatf("Word 0x%h written after the stream was complete", usbData));
      end else begin
        expWord = expWords.pop_front();
        if (usbData !== expWord) begin
          noteFailure($sformatf("FAILED usbData: got 0x%h expected 0x%h", usbData, expWord));
        end
      end
    end
    if (testDone && !prevDone && expWords.size() != 0) begin
      noteFailure($sformatf("testDone rose with %0d words still due", expWords.size()));
    end
    if (prevDone && !testDone && !prevTransmit) begin
      noteFailure("testDone dropped without transmitDone");
    end
    prevDone     = testDone;
    prevTransmit = transmitDone;
    if (testEnd) begin
      if (expWords.size() != 0 || expLoads.size() != 0) begin
        noteFailure($sformatf("Test ended with %0d words and %0d loads missing",
                              expWords.size(), expLoads.size()));
      end
      $display("Test %0d (%s, channel %0d, inject %0d): %0d errors", testNum,
               expSingle ? "single" : "all", expChan, expInject, testErrors);
      testNum++;
    end
  end

endmodule

// File: hw/asicPkg.sv
package asicPkg;

  ////////////////////
  // Channel and DAC indexing
  typedef logic [5:0]   chanIdxT;     // One of 64 channels
  typedef logic [9:0]   dacCodeT;     // Threshold DAC code

  ////////////////////
  // Slow-control fields
  typedef logic [63:0]  ctestMaskT;   // Charge injection, one bit per channel
  typedef logic [191:0] discriMaskT;  // Three bits per channel, channel 0 on top, 1 = enabled

  // Shifted out MSB first, ctestMask leads
  typedef struct packed {
    ctestMaskT  ctestMask;
    dacCodeT    dacBits;     // Code bit-reversed, chip takes LSB first
    discriMaskT discriMask;
  } scParamT;

  localparam int ScBits = $bits(scParamT);  // 266

  // Bit order the chip expects for the DAC field
  function automatic dacCodeT reverseDac(dacCodeT code);
    dacCodeT rev;
    for (int i = 0; i < $bits(dacCodeT); i++) begin
      rev[i] = code[$bits(dacCodeT) - 1 - i];
    end
    return rev;
  endfunction

endpackage

// File: hw/countFifo.sv
module countFifo #(
  parameter int FifoDepth = 4
) (
  input  logic             Clk,
  input  logic             reset_n,
  input  logic             wrEn,
  input  daqPkg::hitCountT wrData,
  input  logic             rdEn,
  output daqPkg::hitCountT rdData,
  output logic             empty,
  output logic             full
);
  import daqPkg::*;

  localparam int PtrW  = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int FillW = $clog2(FifoDepth + 1);

  hitCountT         mem [FifoDepth];
  logic [PtrW-1:0]  wrPtr;
  logic [PtrW-1:0]  rdPtr;
  logic [FillW-1:0] fill;
  logic             doWrite;
  logic             doRead;

  function automatic logic [PtrW-1:0] nextPtr(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(FifoDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty   = (fill == '0);
  assign full    = (fill == FillW'(FifoDepth));
  assign rdData  = mem[rdPtr];  // Head word visible while not empty
  assign doWrite = wrEn && !full;
  assign doRead  = rdEn && !empty;

  always_ff @(posedge Clk) begin
    if (doWrite) begin
      mem[wrPtr] <= wrData;
    end
  end

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      wrPtr <= '0;
      rdPtr <= '0;
      fill  <= '0;
    end else begin
      if (doWrite) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (doRead) begin
        rdPtr <= nextPtr(rdPtr);
      end
      fill <= fill + FillW'(doWrite) - FillW'(doRead);
    end
  end

  assert property (@(posedge Clk) disable iff (!reset_n) wrEn |-> !full);   // Overflow
  assert property (@(posedge Clk) disable iff (!reset_n) rdEn |-> !empty);  // Underflow

endmodule

// File: hw/daqPkg.sv
package daqPkg;

  typedef logic [15:0] dataWordT;   // Output FIFO word
  typedef logic [15:0] hitCountT;   // Saturating hit count

  ////////////////////
  // Stream framing
  localparam dataWordT HeaderWord  = 16'h5343;  // "SC"
  localparam dataWordT TrailerWord = 16'hFF45;

  // Channel word is {tag, 2'b00, channel}
  localparam logic [7:0] TagSingleChan = 8'h43;  // "C"
  localparam logic [7:0] TagAllChan    = 8'h63;  // "c"

  // DAC word is {tag, 2'b00, code}
  localparam logic [3:0] TagDac = 4'hD;

endpackage

// File: hw/scLoader.sv
module scLoader (
  input  logic             Clk,
  input  logic             reset_n,
  input  logic             loadStart,
  input  asicPkg::scParamT scParam,
  output logic             scSerial,
  output logic             scShift,
  output logic             scLatch,
  output logic             loadDone
);
  import asicPkg::*;

  localparam int CntW = $clog2(ScBits);

  logic [ScBits-1:0] shiftReg;
  logic [CntW-1:0]   bitCnt;

  assign scSerial = shiftReg[ScBits-1];  // MSB first

  always_ff @(posedge Clk) begin
    if (loadStart) begin
      shiftReg <= scParam;
    end else if (scShift) begin
      shiftReg <= shiftReg << 1;
    end
  end

  // ScBits shift cycles, then latch, then done
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      scShift  <= 1'b0;
      scLatch  <= 1'b0;
      loadDone <= 1'b0;
      bitCnt   <= '0;
    end else begin
      scLatch  <= 1'b0;
      loadDone <= scLatch;
      if (loadStart) begin
        scShift <= 1'b1;
        bitCnt  <= '0;
      end else if (scShift) begin
        if (bitCnt == CntW'(ScBits - 1)) begin
          scShift <= 1'b0;
          scLatch <= 1'b1;  // Chip takes the word
        end
        bitCnt <= bitCnt + 1'b1;
      end
    end
  end

  assert property (@(posedge Clk) disable iff (!reset_n)
    loadStart |-> !(scShift || scLatch));

endmodule

// File: hw/scurveSequencer.sv
module scurveSequencer #(
  parameter int DacLast      = 1023,
  parameter int SettleCycles = 200
) (
  input  logic              Clk,
  input  logic              reset_n,
  input  logic              testStart,
  input  logic              singleChan,
  input  asicPkg::chanIdxT  singleChanIdx,
  input  logic              ctestInject,
  input  logic              loadDone,
  input  logic              countDone,
  input  logic              fifoEmpty,
  input  daqPkg::hitCountT  fifoData,
  input  logic              usbFull,
  input  logic              transmitDone,
  output asicPkg::scParamT  scParam,
  output logic              loadStart,
  output logic              countStart,
  output asicPkg::chanIdxT  countChan,
  output logic              rdEn,
  output daqPkg::dataWordT  usbData,
  output logic              usbWrite,
  output logic              testDone
);
  import asicPkg::*;
  import daqPkg::*;

  localparam int SettleW = $clog2(SettleCycles + 1);
  localparam discriMaskT DiscriChan0 = discriMaskT'(3'b111) << ($bits(discriMaskT) - 3);

  typedef enum logic [3:0] {
    Idle, Header, ChanWord, DacWord, Load, LoadWait, Settle,
    Count, Drain, CountWord, NextCode, NextChan, Trailer, Done
  } seqStateT;

  seqStateT           state;
  chanIdxT            testChan;
  dacCodeT            dacCode;
  logic [SettleW-1:0] settleCnt;
  logic               modeSingle;   // Latched at start
  logic               injectEn;
  logic               wordStrobe;   // Header, channel, DAC and trailer writes

  assign countChan = testChan;

  // Count words leave in the cycle usbFull is seen low
  assign usbWrite = wordStrobe | (state == CountWord && !usbFull);

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state              <= Idle;
      testChan           <= '0;
      dacCode            <= '0;
      settleCnt          <= '0;
      modeSingle         <= 1'b0;
      injectEn           <= 1'b0;
      wordStrobe         <= 1'b0;
      usbData            <= '0;
      loadStart          <= 1'b0;
      countStart         <= 1'b0;
      rdEn               <= 1'b0;
      testDone           <= 1'b0;
      scParam.ctestMask  <= '0;
      scParam.dacBits    <= '0;
      scParam.discriMask <= '1;
    end else begin
      wordStrobe <= 1'b0;  // Strobes last one cycle
      loadStart  <= 1'b0;
      countStart <= 1'b0;
      rdEn       <= 1'b0;
      case (state)
        Idle: begin
          if (testStart) begin
            modeSingle         <= singleChan;
            injectEn           <= ctestInject;
            testChan           <= singleChan ? singleChanIdx : '0;
            dacCode            <= '0;
            scParam.discriMask <= '1;  // All discriminators on before the first load
            state              <= Header;
          end
        end
        Header: begin
          usbData    <= HeaderWord;
          wordStrobe <= 1'b1;
          state      <= ChanWord;
        end
        ChanWord: begin
          usbData            <= {modeSingle ? TagSingleChan : TagAllChan, 2'b00, testChan};
          wordStrobe         <= 1'b1;
          scParam.ctestMask  <= injectEn ? (ctestMaskT'(1) << testChan) : '0;
          scParam.discriMask <= DiscriChan0 >> (3 * testChan);  // Only this channel
          state              <= DacWord;
        end
        DacWord: begin
          usbData         <= {TagDac, 2'b00, dacCode};
          wordStrobe      <= 1'b1;
          scParam.dacBits <= reverseDac(dacCode);
          state           <= Load;
        end
        Load: begin
          loadStart <= 1'b1;
          state     <= LoadWait;
        end
        LoadWait: begin
          settleCnt <= '0;
          if (loadDone) begin
            state <= Settle;
          end
        end
        Settle: begin
          if (settleCnt == SettleW'(SettleCycles - 1)) begin
            countStart <= 1'b1;
            state      <= Count;
          end else begin
            settleCnt <= settleCnt + 1'b1;
          end
        end
        Count: begin
          if (countDone) begin
            state <= Drain;
          end
        end
        ////////////////////
        // FIFO drain, one count word per entry
        Drain: begin
          if (fifoEmpty) begin
            state <= NextCode;
          end else begin
            rdEn    <= 1'b1;
            usbData <= fifoData;  // First-word fall-through
            state   <= CountWord;
          end
        end
        CountWord: begin
          if (!usbFull) begin
            state <= Drain;
          end
        end
        NextCode: begin
          if (dacCode == dacCodeT'(DacLast)) begin
            dacCode <= '0;
            state   <= NextChan;
          end else begin
            dacCode <= dacCode + 1'b1;
            state   <= DacWord;
          end
        end
        NextChan: begin
          if (modeSingle || testChan == '1) begin
            state <= Trailer;
          end else begin
            testChan <= testChan + 1'b1;
            state    <= ChanWord;
          end
        end
        Trailer: begin
          usbData    <= TrailerWord;
          wordStrobe <= 1'b1;
          testDone   <= 1'b1;  // Held in both modes
          state      <= Done;
        end
        Done: begin
          if (transmitDone) begin
            testDone <= 1'b0;
            state    <= Idle;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  ////////////////////
  // No word of any kind reaches a full output FIFO
  assert property (@(posedge Clk) disable iff (!reset_n) usbWrite |-> !usbFull);

  // Every load of the sweep finishes a fixed time later
  assert property (@(posedge Clk) disable iff (!reset_n)
    loadStart |-> ##(ScBits + 2) loadDone);

endmodule

// File: hw/scurveTop.sv
module scurveTop #(
  parameter int DacLast      = 1023,
  parameter int SettleCycles = 200,
  parameter int WindowCycles = 1000,
  parameter int FifoDepth    = 4
) (
  input  logic             Clk,
  input  logic             reset_n,
  input  logic             testStart,
  input  logic             singleChan,
  input  asicPkg::chanIdxT singleChanIdx,
  input  logic             ctestInject,
  input  logic [63:0]      asicTrigger,
  input  logic             usbFull,
  input  logic             transmitDone,
  output daqPkg::dataWordT usbData,
  output logic             usbWrite,
  output logic             testDone,
  output logic             scSerial,
  output logic             scShift,
  output logic             scLatch
);
  import asicPkg::*;
  import daqPkg::*;

  scParamT  scParam;
  chanIdxT  countChan;
  hitCountT wrData;
  hitCountT rdData;
  logic     loadStart;
  logic     loadDone;
  logic     countStart;
  logic     countDone;
  logic     wrEn;
  logic     rdEn;
  logic     fifoEmpty;
  logic     fifoFull;

  ////////////////////
  // Sweep control and stream output
  scurveSequencer #(.DacLast(DacLast), .SettleCycles(SettleCycles)) seq0 (
    .Clk, .reset_n, .testStart, .singleChan, .singleChanIdx, .ctestInject,
    .loadDone, .countDone, .fifoEmpty, .fifoData(rdData), .usbFull, .transmitDone,
    .scParam, .loadStart, .countStart, .countChan, .rdEn,
    .usbData, .usbWrite, .testDone
  );

  scLoader loader0 (
    .Clk, .reset_n, .loadStart, .scParam, .scSerial, .scShift, .scLatch, .loadDone
  );

  ////////////////////
  // Hit counting path
  triggerCounter #(.WindowCycles(WindowCycles)) counter0 (
    .Clk, .reset_n, .countStart, .countChan, .asicTrigger, .fifoFull,
    .wrEn, .wrData, .countDone
  );

  countFifo #(.FifoDepth(FifoDepth)) fifo0 (
    .Clk, .reset_n, .wrEn, .wrData, .rdEn, .rdData, .empty(fifoEmpty), .full(fifoFull)
  );

endmodule

// File: hw/triggerCounter.sv
module triggerCounter #(
  parameter int WindowCycles = 1000
) (
  input  logic             Clk,
  input  logic             reset_n,
  input  logic             countStart,
  input  asicPkg::chanIdxT countChan,
  input  logic [63:0]      asicTrigger,
  input  logic             fifoFull,
  output logic             wrEn,
  output daqPkg::hitCountT wrData,
  output logic             countDone
);
  import asicPkg::*;
  import daqPkg::*;

  localparam int WinW = (WindowCycles > 1) ? $clog2(WindowCycles) : 1;

  typedef enum logic [1:0] {CntIdle, CntWindow, CntPush} cntStateT;

  cntStateT        state;
  chanIdxT         chanSel;
  logic [2:0]      trigSync;  // Two sync flops plus edge history
  logic            trigRise;
  logic [WinW-1:0] winCnt;
  hitCountT        hitCnt;

  assign trigRise = trigSync[1] & ~trigSync[2];
  assign wrData   = hitCnt;

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state     <= CntIdle;
      chanSel   <= '0;
      trigSync  <= '0;
      winCnt    <= '0;
      hitCnt    <= '0;
      wrEn      <= 1'b0;
      countDone <= 1'b0;
    end else begin
      trigSync  <= {trigSync[1:0], asicTrigger[chanSel]};
      wrEn      <= 1'b0;
      countDone <= wrEn;  // One cycle after the push
      case (state)
        CntIdle: begin
          if (countStart) begin
            chanSel <= countChan;
            hitCnt  <= '0;
            winCnt  <= '0;
            state   <= CntWindow;
          end
        end
        CntWindow: begin
          if (trigRise && hitCnt != '1) begin
            hitCnt <= hitCnt + 1'b1;  // Saturates
          end
          if (winCnt == WinW'(WindowCycles - 1)) begin
            state <= CntPush;
          end else begin
            winCnt <= winCnt + 1'b1;
          end
        end
        CntPush: begin
          if (!fifoFull) begin
            wrEn  <= 1'b1;
            state <= CntIdle;
          end
        end
        default: state <= CntIdle;
      endcase
    end
  end

  assert property (@(posedge Clk) disable iff (!reset_n) wrEn |-> !fifoFull);

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the S-curve sequencer testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module scurveBench -f scurveTop.f -o scurveSim

./obj_dir/scurveSim | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi

// File: scurveTop.f
hw/asicPkg.sv
hw/daqPkg.sv
hw/scLoader.sv
hw/triggerCounter.sv
hw/countFifo.sv
hw/scurveSequencer.sv
hw/scurveTop.sv
bench/scurveChecker.sv
bench/scurveBench.sv
